// File: files.f
hw/wbm_pkg.sv
hw/bus_req_if.sv
hw/req_select.sv
hw/bus_cycle_ctrl.sv
hw/bus_addr_path.sv
hw/wb_master_top.sv
tb/wb_mem_model.sv
tb/tb_wb_master.sv

// File: Makefile
# Verilator build and run for the wishbone bus master testbench

SIM      ?= verilator
VFLAGS   ?= --binary --timing --assert -j 0
TOP      ?= tb_wb_master
FILELIST ?= files.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST OK" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: tb/tb_wb_master.sv
// testbench for the wishbone bus master
// directed fetch, line fill, data read and write traffic against a memory model,
// reference check of every ready pulse, bus hold monitor and watchdog

`timescale 1ns/1ns

module tb_wb_master;

    localparam logic [31:0] FILL_KEY   = 32'h5a3c_96e1;
    localparam int          CLK_PERIOD = 4;
    localparam int          N_TRANS    = 24;
    // four beats of up to four cycles plus the gap after each ack and setup
    localparam int          WORST_CYC  = 24;

    logic        i_clk = 1'b0;
    logic        quick_n_reset;
    logic        i_icache_req, i_icache_qword, o_icache_ready;
    logic [31:0] i_icache_address, o_icache_read_data;
    logic        i_dcache_req, i_dcache_qword, i_dcache_write, o_dcache_ready;
    logic [31:0] i_dcache_address, i_dcache_write_data, o_dcache_read_data;
    logic [3:0]  i_dcache_byte_enable, o_wb_sel;
    logic [31:0] o_wb_adr, o_wb_dat, i_wb_dat;
    logic        o_wb_we, o_wb_cyc, o_wb_stb, i_wb_ack;

    // words written by the test, merged per byte lane
    logic [31:0] shadow [logic [29:0]];
    // word addresses expected at the coming ready pulses of each port
    logic [29:0] exp_i [$];
    logic [29:0] exp_d [$];
    int          errors = 0;
    logic [3:0]  be_list [8] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                 4'b0011, 4'b1100, 4'b1111, 4'b0101};
    logic        hold_seen = 1'b0;
    logic [31:0] held_adr;
    logic [3:0]  held_sel;
    logic        held_we;

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    wb_master_top u_wb_master_top (
        .i_clk(i_clk), .quick_n_reset(quick_n_reset),
        .i_icache_req(i_icache_req), .i_icache_qword(i_icache_qword),
        .i_icache_address(i_icache_address), .o_icache_read_data(o_icache_read_data),
        .o_icache_ready(o_icache_ready), .i_dcache_req(i_dcache_req),
        .i_dcache_qword(i_dcache_qword), .i_dcache_write(i_dcache_write),
        .i_dcache_write_data(i_dcache_write_data), .i_dcache_byte_enable(i_dcache_byte_enable),
        .i_dcache_address(i_dcache_address), .o_dcache_read_data(o_dcache_read_data),
        .o_dcache_ready(o_dcache_ready), .o_wb_adr(o_wb_adr), .o_wb_sel(o_wb_sel),
        .o_wb_we(o_wb_we), .o_wb_dat(o_wb_dat), .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb),
        .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack)
    );

    wb_mem_model #(.FILL_KEY(FILL_KEY)) u_mem (
        .i_clk(i_clk), .quick_n_reset(quick_n_reset), .i_wb_adr(o_wb_adr),
        .i_wb_sel(o_wb_sel), .i_wb_we(o_wb_we), .i_wb_dat(o_wb_dat), .i_wb_cyc(o_wb_cyc),
        .i_wb_stb(o_wb_stb), .o_wb_dat(i_wb_dat), .o_wb_ack(i_wb_ack)
    );

    // ==================================================
    // reference model and reporting
    // ==================================================

    // written value if any, else the address based fill of the memory
    function automatic logic [31:0] expected_word(input logic [29:0] wa);
        if (shadow.exists(wa))
            return shadow[wa];
        return {2'b00, wa} ^ FILL_KEY;
    endfunction

    // low address bits that a data access puts on the bus for its byte enables
    function automatic logic [1:0] lane_offset(input logic [3:0] be);
        case (be)
            4'b0010:          return 2'd1;
            4'b0100, 4'b1100: return 2'd2;
            4'b1000:          return 2'd3;
            default:          return 2'd0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    // every ready pulse must belong to a pending request and carry its word
    always @(posedge i_clk)
    begin
        if (o_icache_ready)
        begin
            assert (exp_i.size() > 0)
            else report_error("instruction ready pulse without a pending fetch");
            if (exp_i.size() > 0)
                check_value("o_icache_read_data", o_icache_read_data,
                            expected_word(exp_i.pop_front()));
        end
        if (o_dcache_ready && !i_dcache_write)
        begin
            assert (exp_d.size() > 0)
            else report_error("data ready pulse without a pending data read");
            if (exp_d.size() > 0)
                check_value("o_dcache_read_data", o_dcache_read_data,
                            expected_word(exp_d.pop_front()));
        end
    end

    // address, lanes and write enable hold while a strobe waits for its ack
    always @(posedge i_clk)
    begin
        // cycle rises and falls together with strobe
        check_value("o_wb_cyc", 32'(o_wb_cyc), 32'(o_wb_stb));
        if (hold_seen)
        begin
            check_value("o_wb_adr", o_wb_adr, held_adr);
            check_value("o_wb_sel", 32'(o_wb_sel), 32'(held_sel));
            check_value("o_wb_we", 32'(o_wb_we), 32'(held_we));
        end
        hold_seen = o_wb_stb && !i_wb_ack;
        held_adr  = o_wb_adr;
        held_sel  = o_wb_sel;
        held_we   = o_wb_we;
    end

    // ==================================================
    // stimulus tasks, entered and left on a falling edge
    // ==================================================

    task automatic wait_ready(input bit from_data, input int count);
        int seen;
        seen = 0;
        while (seen < count)
        begin
            @(posedge i_clk);
            if (from_data ? o_dcache_ready : o_icache_ready)
                seen++;
        end
        @(negedge i_clk);
    endtask

    task automatic fetch(input logic [31:0] addr, input bit qword);
        int n;
        for (n = 0; n < (qword ? 4 : 1); n++)
            exp_i.push_back({addr[31:4], addr[3:2] + 2'(n)});
        i_icache_address = addr;
        i_icache_qword   = qword;
        i_icache_req     = 1'b1;
        wait_ready(1'b0, qword ? 4 : 1);
        i_icache_req = 1'b0;
    endtask

    task automatic data_read(input logic [31:0] addr, input bit qword);
        int n;
        for (n = 0; n < (qword ? 4 : 1); n++)
            exp_d.push_back({addr[31:4], addr[3:2] + 2'(n)});
        i_dcache_address = addr;
        i_dcache_qword   = qword;
        i_dcache_write   = 1'b0;
        i_dcache_req     = 1'b1;
        wait_ready(1'b1, qword ? 4 : 1);
        i_dcache_req = 1'b0;
    endtask

    task automatic data_write(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] wdata);
        logic [31:0] merged;
        int          k;
        i_dcache_address     = addr;
        i_dcache_qword       = 1'b0;
        i_dcache_write       = 1'b1;
        i_dcache_byte_enable = be;
        i_dcache_write_data  = wdata;
        i_dcache_req         = 1'b1;
        // posted write, ready comes with the launch
        wait_ready(1'b1, 1);
        i_dcache_req   = 1'b0;
        i_dcache_write = 1'b0;
        do
            @(posedge i_clk);
        while (!(o_wb_stb && o_wb_we));
        check_value("o_wb_adr", o_wb_adr, {addr[31:2], lane_offset(be)});
        check_value("o_wb_sel", 32'(o_wb_sel), 32'(be));
        check_value("o_wb_dat", o_wb_dat, wdata);
        merged = expected_word(addr[31:2]);
        for (k = 0; k < 4; k++)
            if (be[k])
                merged[8*k +: 8] = wdata[8*k +: 8];
        shadow[addr[31:2]] = merged;
        @(negedge i_clk);
    endtask

    // both ports ask in the same cycle, the data port must be served first
    task automatic race_both(input logic [31:0] iaddr, input logic [31:0] daddr);
        bit first;
        bit got_i;
        bit got_d;
        exp_i.push_back(iaddr[31:2]);
        exp_d.push_back(daddr[31:2]);
        i_icache_address = iaddr;
        i_icache_qword   = 1'b0;
        i_dcache_address = daddr;
        i_dcache_qword   = 1'b0;
        i_icache_req     = 1'b1;
        i_dcache_req     = 1'b1;
        first = 1'b1;
        got_i = 1'b0;
        got_d = 1'b0;
        while (!(got_i && got_d))
        begin
            @(posedge i_clk);
            if (first && (o_icache_ready || o_dcache_ready))
            begin
                assert (o_dcache_ready)
                else report_error("instruction request served ahead of a data request");
                first = 1'b0;
            end
            got_i = got_i || o_icache_ready;
            got_d = got_d || o_dcache_ready;
            @(negedge i_clk);
            i_icache_req = !got_i;
            i_dcache_req = !got_d;
        end
    endtask

    // ==================================================
    // test sequence and watchdog
    // ==================================================

    initial
    begin
        int k;
        quick_n_reset        = 1'b0;
        i_icache_req         = 1'b0;
        i_icache_qword       = 1'b0;
        i_icache_address     = '0;
        i_dcache_req         = 1'b0;
        i_dcache_qword       = 1'b0;
        i_dcache_write       = 1'b0;
        i_dcache_address     = '0;
        i_dcache_write_data  = '0;
        i_dcache_byte_enable = '0;
        repeat (3) @(negedge i_clk);
        quick_n_reset = 1'b1;
        @(posedge i_clk);
        assert (!o_wb_stb && !o_wb_cyc && !o_wb_we && !o_icache_ready && !o_dcache_ready
                && o_wb_adr == 32'h0)
        else report_error("bus outputs not idle after reset");
        // quiet cycles, any ready pulse here has no pending request
        repeat (4) @(negedge i_clk);
        fetch(32'h0000_1000, 1'b0);
        fetch(32'h0000_2344, 1'b0);
        fetch(32'h0000_3014, 1'b1);
        fetch(32'h0000_403c, 1'b1);
        data_read(32'h0000_5028, 1'b1);
        data_read(32'h0000_6004, 1'b0);
        // two words take alternate writes so later lanes merge over earlier ones
        for (k = 0; k < 8; k++)
        begin
            data_write(32'h0000_7003 + 4 * (k % 2), be_list[k],
                       32'ha1b2_c3d4 ^ (k * 32'h0101_0101));
            data_read(32'h0000_7000 + 4 * (k % 2), 1'b0);
        end
        race_both(32'h0000_8000, 32'h0000_9008);
        repeat (8) @(negedge i_clk);
        $display("checks done, %0d errors", errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        #((3 + N_TRANS * WORST_CYC) * 2 * CLK_PERIOD);
        $display("watchdog expired before the test sequence finished, %0d errors", errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tb/wb_mem_model.sv
// wishbone slave memory for the testbench
// sparse word storage with an address based fill, byte lane writes and a
// random wait of zero to three cycles before each acknowledge

`timescale 1ns/1ns

module wb_mem_model
#(
    parameter logic [31:0] FILL_KEY = 32'h0
)
(
    input  logic        i_clk,
    input  logic        quick_n_reset,
    input  logic [31:0] i_wb_adr,
    input  logic [3:0]  i_wb_sel,
    input  logic        i_wb_we,
    input  logic [31:0] i_wb_dat,
    input  logic        i_wb_cyc,
    input  logic        i_wb_stb,
    output logic [31:0] o_wb_dat,
    output logic        o_wb_ack
);

    // only words that were written are stored, the rest come from the fill pattern
    logic [31:0] mem [logic [29:0]];
    integer      seed = 32'hdd6e;
    logic        armed;
    int          wait_left;
    int          delay;
    int          k;
    logic [31:0] word;

    function automatic logic [31:0] read_word(input logic [29:0] wa);
        if (mem.exists(wa))
            return mem[wa];
        return {2'b00, wa} ^ FILL_KEY;
    endfunction

    always @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            o_wb_ack <= 1'b0;
            armed    <= 1'b0;
        end
        else if (o_wb_ack)
        begin
            // one quiet cycle after every ack, the master steps its address here
            o_wb_ack <= 1'b0;
            armed    <= 1'b0;
        end
        else if (i_wb_cyc && i_wb_stb)
        begin
            // a fresh beat draws its wait, a waiting beat keeps counting down
            delay = armed ? wait_left : ($random(seed) & 3);
            if (delay == 0)
            begin
                word = read_word(i_wb_adr[31:2]);
                if (i_wb_we)
                begin
                    for (k = 0; k < 4; k++)
                        if (i_wb_sel[k])
                            word[8*k +: 8] = i_wb_dat[8*k +: 8];
                    mem[i_wb_adr[31:2]] = word;
                end
                o_wb_dat <= word;
                o_wb_ack <= 1'b1;
            end
            else
            begin
                wait_left <= delay - 1;
                armed     <= 1'b1;
            end
        end
    end

endmodule

// File: hw/wb_master_top.sv
// top level of the wishbone bus master
// request selection, bus cycle control and the registered address path

`timescale 1ns/1ns

module wb_master_top
(
    input  logic                           i_clk,
    input  logic                           quick_n_reset,

    // instruction fetch port
    input  logic                           i_icache_req,
    input  logic                           i_icache_qword,
    input  logic [wbm_pkg::WB_ADDR_W-1:0]  i_icache_address,
    output logic [wbm_pkg::WB_DATA_W-1:0]  o_icache_read_data,
    output logic                           o_icache_ready,

    // data port
    input  logic                           i_dcache_req,
    input  logic                           i_dcache_qword,
    input  logic                           i_dcache_write,
    input  logic [wbm_pkg::WB_DATA_W-1:0]  i_dcache_write_data,
    input  logic [wbm_pkg::WB_SEL_W-1:0]   i_dcache_byte_enable,
    input  logic [wbm_pkg::WB_ADDR_W-1:0]  i_dcache_address,
    output logic [wbm_pkg::WB_DATA_W-1:0]  o_dcache_read_data,
    output logic                           o_dcache_ready,

    // wishbone bus
    output logic [wbm_pkg::WB_ADDR_W-1:0]  o_wb_adr,
    output logic [wbm_pkg::WB_SEL_W-1:0]   o_wb_sel,
    output logic                           o_wb_we,
    output logic [wbm_pkg::WB_DATA_W-1:0]  o_wb_dat,
    output logic                           o_wb_cyc,
    output logic                           o_wb_stb,
    input  logic [wbm_pkg::WB_DATA_W-1:0]  i_wb_dat,
    input  logic                           i_wb_ack
);

    logic                load;
    wbm_pkg::wb_state_e  state;

    bus_req_if u_bus_req ();

    // read data is valid whenever the matching ready pulses
    assign o_icache_read_data = i_wb_dat;
    assign o_dcache_read_data = i_wb_dat;

    req_select u_req_select (
        .i_icache_req(i_icache_req), .i_icache_qword(i_icache_qword),
        .i_icache_address(i_icache_address), .i_dcache_req(i_dcache_req),
        .i_dcache_qword(i_dcache_qword), .i_dcache_write(i_dcache_write),
        .i_dcache_write_data(i_dcache_write_data), .i_dcache_byte_enable(i_dcache_byte_enable),
        .i_dcache_address(i_dcache_address), .o_req(u_bus_req.source)
    );

    bus_cycle_ctrl u_bus_cycle_ctrl (
        .i_clk(i_clk), .quick_n_reset(quick_n_reset), .i_wb_ack(i_wb_ack),
        .i_req(u_bus_req.ctrl), .o_wb_stb(o_wb_stb), .o_wb_cyc(o_wb_cyc), .o_wb_we(o_wb_we),
        .o_load(load), .o_state(state), .o_icache_ready(o_icache_ready),
        .o_dcache_ready(o_dcache_ready)
    );

    bus_addr_path u_bus_addr_path (
        .i_clk(i_clk), .quick_n_reset(quick_n_reset), .i_load(load), .i_state(state),
        .i_wb_ack(i_wb_ack), .i_req(u_bus_req.dp), .o_wb_adr(o_wb_adr), .o_wb_sel(o_wb_sel),
        .o_wb_dat(o_wb_dat)
    );

endmodule

// File: hw/bus_addr_path.sv
// wishbone address path
// captures address, byte lanes and write data at the start of an access and
// steps the beat index through a wrapping line fill

`timescale 1ns/1ns

module bus_addr_path
(
    input  logic                           i_clk,
    input  logic                           quick_n_reset,
    input  logic                           i_load,
    input  wbm_pkg::wb_state_e             i_state,
    input  logic                           i_wb_ack,
    bus_req_if.dp                          i_req,

    output logic [wbm_pkg::WB_ADDR_W-1:0]  o_wb_adr,
    output logic [wbm_pkg::WB_SEL_W-1:0]   o_wb_sel,
    output logic [wbm_pkg::WB_DATA_W-1:0]  o_wb_dat
);

    wbm_pkg::wb_addr_u              adr_r;
    logic [wbm_pkg::WB_SEL_W-1:0]   sel_r;
    logic [wbm_pkg::WB_DATA_W-1:0]  dat_r;
    logic                           in_burst;
    logic                           burst_step;

    // the three leading burst states are the ones whose ack moves to another word
    assign in_burst   = i_state inside {wbm_pkg::WB_BURST1, wbm_pkg::WB_BURST2,
                                        wbm_pkg::WB_BURST3};
    assign burst_step = in_burst && i_wb_ack;

    // ==================================================
    // address register
    // ==================================================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
            adr_r <= '0;
        else if (i_load)
            adr_r <= i_req.req_addr;
        else if (burst_step)
            // only the beat index moves, so the burst wraps inside the line
            adr_r.f.beat <= adr_r.f.beat + wbm_pkg::BEAT_W'(1);
    end

    // lanes and write data only change when a new access is captured
    always_ff @(posedge i_clk)
    begin
        if (i_load)
        begin
            sel_r <= i_req.req_sel;
            dat_r <= i_req.req_wdata;
        end
    end

    assign o_wb_adr = adr_r.word;
    assign o_wb_sel = sel_r;
    assign o_wb_dat = dat_r;

    // a line fill never leaves the line it started in
    a_line_fixed: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        in_burst |=> $stable(adr_r.f.line));

endmodule

// File: hw/bus_cycle_ctrl.sv
// wishbone bus cycle controller
// runs the idle, burst and ack wait state machine, owns strobe, cycle and
// write enable, records the access owner and produces the ready pulses

`timescale 1ns/1ns

module bus_cycle_ctrl
(
    input  logic                 i_clk,
    input  logic                 quick_n_reset,
    input  logic                 i_wb_ack,
    bus_req_if.ctrl              i_req,

    output logic                 o_wb_stb,
    output logic                 o_wb_cyc,
    output logic                 o_wb_we,
    output logic                 o_load,
    output wbm_pkg::wb_state_e   o_state,
    output logic                 o_icache_ready,
    output logic                 o_dcache_ready
);

    wbm_pkg::wb_state_e  state_r;

    // high when the data port owns the running access
    logic                owner_dcache_r;

    // a posted write is on the bus and has not been acknowledged yet
    logic                wr_outstanding_r;

    // set for one cycle after the last instruction beat so that a fetch
    // request still held in that cycle is not served twice
    logic                icache_hold_r;

    logic                icache_blocked;
    logic                rd_ack;
    logic                last_ack;

    // ==================================================
    // start and ready decode
    // ==================================================

    assign icache_blocked = icache_hold_r && !i_req.req_from_dcache;

    // a new access only starts from idle
    assign o_load = (state_r == wbm_pkg::WB_IDLE) && i_req.req_valid && !icache_blocked;

    // read beats end on ack, a write ack is not a read beat
    assign rd_ack   = i_wb_ack && !wr_outstanding_r && (state_r != wbm_pkg::WB_IDLE);
    assign last_ack = rd_ack && (state_r == wbm_pkg::WB_WAIT_ACK);

    assign o_icache_ready = rd_ack && !owner_dcache_r;

    // writes are posted so the data port is released as soon as the write launches
    assign o_dcache_ready = (rd_ack && owner_dcache_r) || (o_load && i_req.req_write);

    assign o_state = state_r;

    // ==================================================
    // bus state machine
    // ==================================================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state_r          <= wbm_pkg::WB_IDLE;
            o_wb_stb         <= 1'b0;
            o_wb_cyc         <= 1'b0;
            o_wb_we          <= 1'b0;
            owner_dcache_r   <= 1'b0;
            wr_outstanding_r <= 1'b0;
            icache_hold_r    <= 1'b0;
        end
        else
        begin
            icache_hold_r <= last_ack && !owner_dcache_r;

            case (state_r)
                wbm_pkg::WB_IDLE:
                begin
                    if (o_load)
                    begin
                        // strobe and cycle rise together with the new address
                        o_wb_stb         <= 1'b1;
                        o_wb_cyc         <= 1'b1;
                        o_wb_we          <= i_req.req_write;
                        owner_dcache_r   <= i_req.req_from_dcache;
                        wr_outstanding_r <= i_req.req_write;
                        state_r          <= i_req.req_burst ? wbm_pkg::WB_BURST1
                                                            : wbm_pkg::WB_WAIT_ACK;
                    end
                end

                // first three beats of a line fill, strobe stays up throughout
                wbm_pkg::WB_BURST1:
                    if (i_wb_ack)
                        state_r <= wbm_pkg::WB_BURST2;

                wbm_pkg::WB_BURST2:
                    if (i_wb_ack)
                        state_r <= wbm_pkg::WB_BURST3;

                wbm_pkg::WB_BURST3:
                    if (i_wb_ack)
                        state_r <= wbm_pkg::WB_WAIT_ACK;

                // last or only beat, the bus is released on its ack
                wbm_pkg::WB_WAIT_ACK:
                begin
                    if (i_wb_ack)
                    begin
                        o_wb_stb         <= 1'b0;
                        o_wb_cyc         <= 1'b0;
                        o_wb_we          <= 1'b0;
                        wr_outstanding_r <= 1'b0;
                        state_r          <= wbm_pkg::WB_IDLE;
                    end
                end

                default:
                    state_r <= wbm_pkg::WB_IDLE;
            endcase
        end
    end

    // ==================================================
    // assertions
    // ==================================================

    // idle only moves to a burst or to a single beat
    a_idle_next: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_r == wbm_pkg::WB_IDLE) |=>
        (state_r inside {wbm_pkg::WB_IDLE, wbm_pkg::WB_BURST1, wbm_pkg::WB_WAIT_ACK}));

    // each acked burst beat steps to the next state, the third lands on ack wait
    a_burst_step: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_r inside {wbm_pkg::WB_BURST1, wbm_pkg::WB_BURST2, wbm_pkg::WB_BURST3})
        && i_wb_ack |=> (state_r == wbm_pkg::wb_state_e'($past(state_r) + 3'd1)));

    a_wait_done: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_r == wbm_pkg::WB_WAIT_ACK) && i_wb_ack |=> (state_r == wbm_pkg::WB_IDLE));

    // a strobe without ack must not be withdrawn
    a_stb_hold: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        o_wb_stb && !i_wb_ack |=> o_wb_stb);

    a_ready_excl: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        !(o_icache_ready && o_dcache_ready));

endmodule

// File: hw/req_select.sv
// request selector for the wishbone master
// picks the data port over the instruction port and forms the bus address,
// byte lanes and write data of the winning request

`timescale 1ns/1ns

module req_select
(
    // instruction fetch port
    input  logic                           i_icache_req,
    input  logic                           i_icache_qword,
    input  logic [wbm_pkg::WB_ADDR_W-1:0]  i_icache_address,

    // data port
    input  logic                           i_dcache_req,
    input  logic                           i_dcache_qword,
    input  logic                           i_dcache_write,
    input  logic [wbm_pkg::WB_DATA_W-1:0]  i_dcache_write_data,
    input  logic [wbm_pkg::WB_SEL_W-1:0]   i_dcache_byte_enable,
    input  logic [wbm_pkg::WB_ADDR_W-1:0]  i_dcache_address,

    // winning request
    bus_req_if.source                      o_req
);

    logic [wbm_pkg::WB_SEL_W-1:0]  sel_c;
    logic [1:0]                    byte_off_c;
    wbm_pkg::wb_addr_u             addr_c;

    // ==================================================
    // priority and access kind
    // ==================================================

    // any pending request from either side starts an access
    assign o_req.req_valid       = i_dcache_req || i_icache_req;

    // the data port wins whenever it asks
    assign o_req.req_from_dcache = i_dcache_req;

    // only the data port writes
    assign o_req.req_write       = i_dcache_req && i_dcache_write;

    // a line fill is a read burst, writes are always single words
    assign o_req.req_burst       = i_dcache_req ? (i_dcache_qword && !i_dcache_write)
                                                : i_icache_qword;

    // ==================================================
    // byte lanes and address
    // ==================================================

    // writes carry their own byte enables, reads take the full word
    assign sel_c = o_req.req_write ? i_dcache_byte_enable : wbm_pkg::SEL_ALL;

    // low address bits follow the lowest byte covered by the lanes
    // a full word and any odd pattern fall back to offset zero
    always_comb
    begin
        case (sel_c)
            4'b0001: byte_off_c = 2'd0;
            4'b0010: byte_off_c = 2'd1;
            4'b0100: byte_off_c = 2'd2;
            4'b1000: byte_off_c = 2'd3;
            4'b0011: byte_off_c = 2'd0;
            4'b1100: byte_off_c = 2'd2;
            default: byte_off_c = 2'd0;
        endcase
    end

    always_comb
    begin
        if (i_dcache_req)
        begin
            // data access keeps line and beat and takes the lane based offset
            addr_c.word       = i_dcache_address;
            addr_c.f.byte_off = byte_off_c;
        end
        else
        begin
            // instruction fetches are always word aligned
            addr_c.word       = i_icache_address;
            addr_c.f.byte_off = 2'd0;
        end
    end

    assign o_req.req_addr  = addr_c;
    assign o_req.req_sel   = sel_c;

    // write data only matters for data writes, passed through unchanged
    assign o_req.req_wdata = i_dcache_write_data;

endmodule

// File: hw/bus_req_if.sv
// selected request bundle between the request selector, the bus controller
// and the address path

`timescale 1ns/1ns

interface bus_req_if;

    // control view of the winning request
    logic                           req_valid;
    logic                           req_write;
    logic                           req_burst;
    logic                           req_from_dcache;

    // payload of the winning request
    wbm_pkg::wb_addr_u              req_addr;
    logic [wbm_pkg::WB_SEL_W-1:0]   req_sel;
    logic [wbm_pkg::WB_DATA_W-1:0]  req_wdata;

    // the selector produces everything
    modport source (
        output req_valid, req_write, req_burst, req_from_dcache,
        output req_addr, req_sel, req_wdata
    );

    // the controller only needs to know what kind of access to run and for whom
    modport ctrl (
        input req_valid, req_write, req_burst, req_from_dcache
    );

    // the address path only captures the payload
    modport dp (
        input req_addr, req_sel, req_wdata
    );

endinterface

// File: hw/wbm_pkg.sv
// shared definitions for the wishbone bus master
// bus widths, burst length, bus state encoding and the address word layout

package wbm_pkg;

    // bus geometry, fixed by the wishbone usage of the core
    localparam int WB_ADDR_W   = 32;
    localparam int WB_DATA_W   = 32;
    localparam int WB_SEL_W    = 4;
    localparam int BURST_BEATS = 4;

    // width of the beat index inside a cache line
    localparam int BEAT_W = $clog2(BURST_BEATS);

    // byte enable for reads, all four lanes
    localparam logic [WB_SEL_W-1:0] SEL_ALL = 4'b1111;

    // bus state machine, idle plus the three leading burst beats and a final ack wait
    typedef enum logic [2:0] {
        WB_IDLE     = 3'd0,
        WB_BURST1   = 3'd1,
        WB_BURST2   = 3'd2,
        WB_BURST3   = 3'd3,
        WB_WAIT_ACK = 3'd4
    } wb_state_e;

    // one address word, seen either raw or split into line, beat and byte offset
    typedef union packed {
        logic [WB_ADDR_W-1:0] word;
        struct packed {
            logic [WB_ADDR_W-BEAT_W-3:0] line;
            logic [BEAT_W-1:0]           beat;
            logic [1:0]                  byte_off;
        } f;
    } wb_addr_u;

endpackage
